// File: compile.f
logic/maiPkg.sv
logic/burstFifo.sv
logic/writeArbiter.sv
logic/macWriteIssuer.sv
logic/memAccessInterconnect.sv
verification/memAccessInterconnect_properties.sv
verification/memAccessInterconnect_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the write path testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f \
  --top-module memAccessInterconnect_tb -o memAccessInterconnect_sim \
  && ./obj_dir/memAccessInterconnect_sim \
  || { echo "Simulation run failed"; exit 1; }

// File: verification/memAccessInterconnect_tb.sv
`timescale 1ns/1ps
// Testbench for the write path; the scoreboard assumes the FIFO depths set here
// Masters only send bursts whose beat count matches the length code
module memAccessInterconnect_tb;
  import maiPkg::*;

  localparam int NUM_BURSTS = 50;
  localparam int HDR_DEPTH  = 4;
  localparam int DATA_DEPTH = 16;

  logic              clk;
  logic              resetn;
  logic              stall;
  // Index 0 is the if master, 1 is dm
  logic              mValid [2];
  logic [ADDR_W-1:0] mAddr [2];
  logic [TAG_W-1:0]  mTag [2];
  logic [ID_W-1:0]   mId [2];
  logic [LEN_W-1:0]  mLen [2];
  logic [QOS_W-1:0]  mQos [2];
  logic              mReady [2];
  logic              mDataValid [2];
  logic [DATA_W-1:0] mData [2];
  logic [MASK_W-1:0] mMask [2];
  logic              mEoD [2];
  logic              mDataReady [2];
  logic              macValidWr;
  logic [ADDR_W-1:0] macAddrWr;
  logic [TAG_W-1:0]  macTagWr;
  logic [ID_W-1:0]   macIdWr;
  logic [LEN_W-1:0]  macLenWr;
  logic [QOS_W-1:0]  macQoSWr;
  logic              macReadyWr;
  logic              macDataValid;
  logic [DATA_W-1:0] macDataWr;
  logic [MASK_W-1:0] macMaskWr;
  logic              macEoD;
  logic              macDataReady;
  int                orderQ [$];
  wrHeaderT          hdrQ [$];
  wrBeatT            ifBeatQ [$];
  wrBeatT            dmBeatQ [$];
  int                curMaster;
  int                beatsLeft;
  int                seedVal;
  logic              hdrFullSeen;
  logic              beatFullSeen;

  memAccessInterconnect #(.HDR_DEPTH(HDR_DEPTH), .DATA_DEPTH(DATA_DEPTH)) dut_i (
    .clk(clk), .resetn(resetn),
    .ifValidWr(mValid[0]), .ifAddrWr(mAddr[0]), .ifTagWr(mTag[0]), .ifIdWr(mId[0]),
    .ifLenWr(mLen[0]), .ifQoSWr(mQos[0]), .ifReadyWr(mReady[0]),
    .ifDataValid(mDataValid[0]), .ifDataWr(mData[0]), .ifMaskWr(mMask[0]),
    .ifEoD(mEoD[0]), .ifDataReady(mDataReady[0]),
    .dmValidWr(mValid[1]), .dmAddrWr(mAddr[1]), .dmTagWr(mTag[1]), .dmIdWr(mId[1]),
    .dmLenWr(mLen[1]), .dmQoSWr(mQos[1]), .dmReadyWr(mReady[1]),
    .dmDataValid(mDataValid[1]), .dmDataWr(mData[1]), .dmMaskWr(mMask[1]),
    .dmEoD(mEoD[1]), .dmDataReady(mDataReady[1]),
    .macValidWr(macValidWr), .macAddrWr(macAddrWr), .macTagWr(macTagWr),
    .macIdWr(macIdWr), .macLenWr(macLenWr), .macQoSWr(macQoSWr), .macReadyWr(macReadyWr),
    .macDataValid(macDataValid), .macDataWr(macDataWr), .macMaskWr(macMaskWr),
    .macEoD(macEoD), .macDataReady(macDataReady)
  );

  // Length code n gives 2**n beats
  function automatic int expectedBeats(input logic [LEN_W-1:0] len);
    return 1 << len;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, expected, actual);
      $display("Errors found");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic checkHeader();
    wrHeaderT exp;
    if (orderQ.size() == 0) begin
      $display("Controller header at %0t without any accepted master request", $time);
      $display("Errors found");
      $fatal(1, "Unexpected controller header");
    end else begin
      checkValue("beats left before macValidWr", 32'd0, 32'(beatsLeft));
      curMaster = orderQ.pop_front();
      exp = hdrQ.pop_front();
      checkValue("macAddrWr", exp.addr, macAddrWr);
      checkValue("macTagWr", 32'(exp.tag), 32'(macTagWr));
      checkValue("macIdWr", 32'(exp.id), 32'(macIdWr));
      checkValue("macLenWr", 32'(exp.len), 32'(macLenWr));
      checkValue("macQoSWr", 32'(exp.qos), 32'(macQoSWr));
      beatsLeft = expectedBeats(exp.len);
    end
  endtask

  task automatic checkBeat();
    wrBeatT exp;
    int     queued;
    queued = (curMaster == 0) ? ifBeatQ.size() : dmBeatQ.size();
    if (beatsLeft == 0 || queued == 0) begin
      $display("Controller beat at %0t outside a burst or never sent by the master", $time);
      $display("Errors found");
      $fatal(1, "Unexpected controller beat");
    end else begin
      if (curMaster == 0) begin
        exp = ifBeatQ.pop_front();
      end else begin
        exp = dmBeatQ.pop_front();
      end
      checkValue("macDataWr", exp.data, macDataWr);
      checkValue("macMaskWr", 32'(exp.mask), 32'(macMaskWr));
      checkValue("macEoD", 32'(beatsLeft == 1), 32'(macEoD));
      beatsLeft = beatsLeft - 1;
    end
  endtask

  // One header then its beats, with random gaps between beats
  task automatic sendBurst(input int m, input logic [QOS_W-1:0] qos,
                           input logic [LEN_W-1:0] len);
    int beats;
    beats = expectedBeats(len);
    @(negedge clk);
    mValid[m] = 1'b1;
    mAddr[m] = $urandom();
    mTag[m] = TAG_W'($urandom());
    mId[m] = ID_W'($urandom());
    mLen[m] = len;
    mQos[m] = qos;
    do @(posedge clk); while (!mReady[m]);
    @(negedge clk);
    mValid[m] = 1'b0;
    for (int b = 0; b < beats; b++) begin
      while ($urandom_range(3) == 0) @(negedge clk);
      mDataValid[m] = 1'b1;
      mData[m] = $urandom();
      mMask[m] = MASK_W'($urandom());
      mEoD[m] = (b == beats - 1);
      do @(posedge clk); while (!mDataReady[m]);
      @(negedge clk);
      mDataValid[m] = 1'b0;
      mEoD[m] = 1'b0;
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    repeat (NUM_BURSTS * MAX_BEATS * 20) @(posedge clk);
    $display("Errors found");
    $fatal(1, "Timeout: the bursts did not all reach the controller in time");
  end

  // Controller side, random ready while stalling
  initial begin
    macReadyWr = 1'b0;
    macDataReady = 1'b0;
    forever begin
      @(negedge clk);
      if (stall) begin
        macReadyWr = ($urandom_range(3) == 0);
        macDataReady = ($urandom_range(3) == 0);
      end else begin
        macReadyWr = 1'b1;
        macDataReady = 1'b1;
      end
    end
  end

  always @(posedge clk) begin : monitor
    wrHeaderT h;
    wrBeatT   b;
    if (resetn) begin
      // Queued beats are exactly the beat FIFO contents
      if (ifBeatQ.size() + dmBeatQ.size() >= DATA_DEPTH) begin
        beatFullSeen = 1'b1;
        checkValue("ifDataReady with beat FIFO full", 32'd0, 32'(mDataReady[0]));
        checkValue("dmDataReady with beat FIFO full", 32'd0, 32'(mDataReady[1]));
      end
      // At most one waiting header sits in the issuer, the rest in the FIFO
      if (orderQ.size() > HDR_DEPTH) begin
        hdrFullSeen = 1'b1;
        checkValue("ifReadyWr with header FIFO full", 32'd0, 32'(mReady[0]));
        checkValue("dmReadyWr with header FIFO full", 32'd0, 32'(mReady[1]));
      end
      for (int m = 0; m < 2; m++) begin
        if (mValid[m] && mReady[m]) begin
          if (mValid[0] && mValid[1]) begin
            checkValue("granted master", (mQos[0] > mQos[1]) ? 32'd0 : 32'd1, 32'(m));
          end
          h.addr = mAddr[m];
          h.tag = mTag[m];
          h.id = mId[m];
          h.len = mLen[m];
          h.qos = mQos[m];
          orderQ.push_back(m);
          hdrQ.push_back(h);
        end
        if (mDataValid[m] && mDataReady[m]) begin
          b.data = mData[m];
          b.mask = mMask[m];
          if (m == 0) begin
            ifBeatQ.push_back(b);
          end else begin
            dmBeatQ.push_back(b);
          end
        end
      end
      if (macValidWr && macReadyWr) begin
        checkHeader();
      end
      if (macDataValid && macDataReady) begin
        checkBeat();
      end
    end
  end

  initial begin
    seedVal = $urandom(32'h30664636);
    resetn = 1'b0;
    stall = 1'b0;
    curMaster = 0;
    beatsLeft = 0;
    hdrFullSeen = 1'b0;
    beatFullSeen = 1'b0;
    for (int m = 0; m < 2; m++) begin
      mValid[m] = 1'b0;
      mAddr[m] = '0;
      mTag[m] = '0;
      mId[m] = '0;
      mLen[m] = '0;
      mQos[m] = '0;
      mDataValid[m] = 1'b0;
      mData[m] = '0;
      mMask[m] = '0;
      mEoD[m] = 1'b0;
    end
    repeat (8) @(negedge clk);
    resetn = 1'b1;

    // Lone if bursts, every length code
    for (int len = 0; len < 4; len++) begin
      sendBurst(0, QOS_W'($urandom()), LEN_W'(len));
    end

    // Same-cycle requests: if higher, tie, dm higher
    fork
      sendBurst(0, 4'd9, LEN_W'($urandom()));
      sendBurst(1, 4'd3, LEN_W'($urandom()));
    join
    fork
      sendBurst(0, 4'd5, LEN_W'($urandom()));
      sendBurst(1, 4'd5, LEN_W'($urandom()));
    join
    fork
      sendBurst(0, 4'd2, LEN_W'($urandom()));
      sendBurst(1, 4'd11, LEN_W'($urandom()));
    join

    // Both masters busy against a stalling controller
    stall = 1'b1;
    fork
      repeat (20) sendBurst(0, QOS_W'($urandom()), LEN_W'($urandom()));
      repeat (20) sendBurst(1, QOS_W'($urandom()), LEN_W'($urandom()));
    join

    while (orderQ.size() != 0 || beatsLeft != 0) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);
    if (hdrQ.size() != 0 || ifBeatQ.size() != 0 || dmBeatQ.size() != 0) begin
      $display("Accepted headers or beats never reached the controller");
      $display("Errors found");
      $fatal(1, "Scoreboard not empty at the end of the run");
    end else if (!hdrFullSeen || !beatFullSeen) begin
      $display("The stalling controller never filled the header and beat FIFOs");
      $display("Errors found");
      $fatal(1, "FIFO full condition not reached");
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: verification/memAccessInterconnect_properties.sv
`timescale 1ns/1ps
// Controller-side handshake checks, bound into memAccessInterconnect
// Payload only has to hold while valid waits for ready
module memAccessInterconnect_properties (
  input logic                      clk,
  input logic                      resetn,
  input logic                      macValidWr,
  input logic [maiPkg::ADDR_W-1:0] macAddrWr,
  input logic [maiPkg::TAG_W-1:0]  macTagWr,
  input logic [maiPkg::ID_W-1:0]   macIdWr,
  input logic [maiPkg::LEN_W-1:0]  macLenWr,
  input logic [maiPkg::QOS_W-1:0]  macQoSWr,
  input logic                      macReadyWr,
  input logic                      macDataValid,
  input logic [maiPkg::DATA_W-1:0] macDataWr,
  input logic [maiPkg::MASK_W-1:0] macMaskWr,
  input logic                      macEoD,
  input logic                      macDataReady
);

  // Header waits for macReadyWr
  hdrHold: assert property (@(posedge clk) disable iff (!resetn)
    macValidWr && !macReadyWr |=> macValidWr &&
      $stable({macAddrWr, macTagWr, macIdWr, macLenWr, macQoSWr}))
    else $error("Controller header changed or dropped before macReadyWr");

  // Beat waits for macDataReady
  beatHold: assert property (@(posedge clk) disable iff (!resetn)
    macDataValid && !macDataReady |=> macDataValid &&
      $stable({macDataWr, macMaskWr, macEoD}))
    else $error("Controller beat changed or dropped before macDataReady");

  // Quiet controller side on leaving reset
  resetQuiet: assert property (@(posedge clk)
    $rose(resetn) |-> !macValidWr && !macDataValid && !macEoD)
    else $error("Controller valid or EoD high right after reset");

endmodule

bind memAccessInterconnect memAccessInterconnect_properties props_i (
  .clk(clk), .resetn(resetn),
  .macValidWr(macValidWr), .macAddrWr(macAddrWr), .macTagWr(macTagWr),
  .macIdWr(macIdWr), .macLenWr(macLenWr), .macQoSWr(macQoSWr), .macReadyWr(macReadyWr),
  .macDataValid(macDataValid), .macDataWr(macDataWr), .macMaskWr(macMaskWr),
  .macEoD(macEoD), .macDataReady(macDataReady)
);

// File: logic/memAccessInterconnect.sv
`timescale 1ns/1ps
// Write path of the memory access interconnect, if and dm into one controller port
// Single clock; headers and beats are queued separately and replayed in order
// DATA_DEPTH must be at least MAX_BEATS
module memAccessInterconnect #(
  parameter int HDR_DEPTH  = 4,
  parameter int DATA_DEPTH = 16
) (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      ifValidWr,
  input  logic [maiPkg::ADDR_W-1:0] ifAddrWr,
  input  logic [maiPkg::TAG_W-1:0]  ifTagWr,
  input  logic [maiPkg::ID_W-1:0]   ifIdWr,
  input  logic [maiPkg::LEN_W-1:0]  ifLenWr,
  input  logic [maiPkg::QOS_W-1:0]  ifQoSWr,
  output logic                      ifReadyWr,
  input  logic                      ifDataValid,
  input  logic [maiPkg::DATA_W-1:0] ifDataWr,
  input  logic [maiPkg::MASK_W-1:0] ifMaskWr,
  input  logic                      ifEoD,
  output logic                      ifDataReady,
  input  logic                      dmValidWr,
  input  logic [maiPkg::ADDR_W-1:0] dmAddrWr,
  input  logic [maiPkg::TAG_W-1:0]  dmTagWr,
  input  logic [maiPkg::ID_W-1:0]   dmIdWr,
  input  logic [maiPkg::LEN_W-1:0]  dmLenWr,
  input  logic [maiPkg::QOS_W-1:0]  dmQoSWr,
  output logic                      dmReadyWr,
  input  logic                      dmDataValid,
  input  logic [maiPkg::DATA_W-1:0] dmDataWr,
  input  logic [maiPkg::MASK_W-1:0] dmMaskWr,
  input  logic                      dmEoD,
  output logic                      dmDataReady,
  output logic                      macValidWr,
  output logic [maiPkg::ADDR_W-1:0] macAddrWr,
  output logic [maiPkg::TAG_W-1:0]  macTagWr,
  output logic [maiPkg::ID_W-1:0]   macIdWr,
  output logic [maiPkg::LEN_W-1:0]  macLenWr,
  output logic [maiPkg::QOS_W-1:0]  macQoSWr,
  input  logic                      macReadyWr,
  output logic                      macDataValid,
  output logic [maiPkg::DATA_W-1:0] macDataWr,
  output logic [maiPkg::MASK_W-1:0] macMaskWr,
  output logic                      macEoD,
  input  logic                      macDataReady
);
  import maiPkg::*;

  logic     hdrPush;
  logic     hdrFull;
  logic     hdrPop;
  logic     hdrEmpty;
  wrHeaderT hdrIn;
  wrHeaderT hdrOut;
  logic     beatPush;
  logic     beatFull;
  logic     beatPop;
  logic     beatEmpty;
  wrBeatT   beatIn;
  wrBeatT   beatOut;

  // A whole burst has to fit in the beat FIFO
  if (DATA_DEPTH < MAX_BEATS) begin : gDepthCheck
    $error("DATA_DEPTH is smaller than MAX_BEATS");
  end

  burstFifo #(.itemT(wrHeaderT), .DEPTH(HDR_DEPTH)) hdrFifo (
    .clk(clk), .resetn(resetn),
    .push(hdrPush), .pushItem(hdrIn), .full(hdrFull),
    .pop(hdrPop), .popItem(hdrOut), .empty(hdrEmpty)
  );

  burstFifo #(.itemT(wrBeatT), .DEPTH(DATA_DEPTH)) beatFifo (
    .clk(clk), .resetn(resetn),
    .push(beatPush), .pushItem(beatIn), .full(beatFull),
    .pop(beatPop), .popItem(beatOut), .empty(beatEmpty)
  );

  writeArbiter arbiter (.*, .hdrItem(hdrIn), .beatItem(beatIn));

  macWriteIssuer issuer (.*, .hdrItem(hdrOut), .beatItem(beatOut));

endmodule

// File: logic/macWriteIssuer.sv
`timescale 1ns/1ps
// Replays queued write bursts to the memory controller, one at a time
// Header outputs are registered; beats come straight from the FIFO head
// Beat count per burst comes from the header length code
module macWriteIssuer (
  input  logic                      clk,
  input  logic                      resetn,
  // Header FIFO pop side
  input  logic                      hdrEmpty,
  output logic                      hdrPop,
  input  maiPkg::wrHeaderT          hdrItem,
  // Beat FIFO pop side
  input  logic                      beatEmpty,
  output logic                      beatPop,
  input  maiPkg::wrBeatT            beatItem,
  // Memory controller
  output logic                      macValidWr,
  output logic [maiPkg::ADDR_W-1:0] macAddrWr,
  output logic [maiPkg::TAG_W-1:0]  macTagWr,
  output logic [maiPkg::ID_W-1:0]   macIdWr,
  output logic [maiPkg::LEN_W-1:0]  macLenWr,
  output logic [maiPkg::QOS_W-1:0]  macQoSWr,
  input  logic                      macReadyWr,
  output logic                      macDataValid,
  output logic [maiPkg::DATA_W-1:0] macDataWr,
  output logic [maiPkg::MASK_W-1:0] macMaskWr,
  output logic                      macEoD,
  input  logic                      macDataReady
);
  import maiPkg::*;

  typedef enum logic [1:0] {
    ISS_IDLE,
    ISS_HDR,
    ISS_DATA
  } issStateT;

  issStateT              state;
  logic [BEAT_CNT_W-1:0] beatCnt;
  logic                  lastBeat;

  assign hdrPop = (state == ISS_IDLE) & ~hdrEmpty;

  // Valid waits for the beat to reach the FIFO
  assign macDataValid = (state == ISS_DATA) & ~beatEmpty;
  assign macDataWr    = beatItem.data;
  assign macMaskWr    = beatItem.mask;
  assign lastBeat     = (beatCnt == BEAT_CNT_W'(1));
  assign macEoD       = macDataValid & lastBeat;
  assign beatPop      = macDataValid & macDataReady;

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state      <= ISS_IDLE;
      macValidWr <= 1'b0;
      beatCnt    <= '0;
    end else begin
      case (state)
        ISS_IDLE: begin
          if (hdrPop) begin
            macValidWr <= 1'b1;
            state      <= ISS_HDR;
          end
        end
        ISS_HDR: begin
          if (macReadyWr) begin
            macValidWr <= 1'b0;
            beatCnt    <= lenToBeats(macLenWr);
            state      <= ISS_DATA;
          end
        end
        ISS_DATA: begin
          if (beatPop) begin
            beatCnt <= beatCnt - 1'b1;
            if (lastBeat) begin
              state <= ISS_IDLE;
            end
          end
        end
        default: state <= ISS_IDLE;
      endcase
    end
  end

  // Header fields captured on pop, held until the next pop
  always_ff @(posedge clk) begin
    if (hdrPop) begin
      macAddrWr <= hdrItem.addr;
      macTagWr  <= hdrItem.tag;
      macIdWr   <= hdrItem.id;
      macLenWr  <= hdrItem.len;
      macQoSWr  <= hdrItem.qos;
    end
  end

endmodule

// File: logic/writeArbiter.sv
`timescale 1ns/1ps
// QoS write arbiter between the if and dm masters
// if wins only with strictly higher QoS, dm takes ties
// Grant is held until the EoD beat; beat count is not checked
module writeArbiter (
  input  logic                      clk,
  input  logic                      resetn,
  // Instruction fetch master
  input  logic                      ifValidWr,
  input  logic [maiPkg::ADDR_W-1:0] ifAddrWr,
  input  logic [maiPkg::TAG_W-1:0]  ifTagWr,
  input  logic [maiPkg::ID_W-1:0]   ifIdWr,
  input  logic [maiPkg::LEN_W-1:0]  ifLenWr,
  input  logic [maiPkg::QOS_W-1:0]  ifQoSWr,
  output logic                      ifReadyWr,
  input  logic                      ifDataValid,
  input  logic [maiPkg::DATA_W-1:0] ifDataWr,
  input  logic [maiPkg::MASK_W-1:0] ifMaskWr,
  input  logic                      ifEoD,
  output logic                      ifDataReady,
  // Data memory master
  input  logic                      dmValidWr,
  input  logic [maiPkg::ADDR_W-1:0] dmAddrWr,
  input  logic [maiPkg::TAG_W-1:0]  dmTagWr,
  input  logic [maiPkg::ID_W-1:0]   dmIdWr,
  input  logic [maiPkg::LEN_W-1:0]  dmLenWr,
  input  logic [maiPkg::QOS_W-1:0]  dmQoSWr,
  output logic                      dmReadyWr,
  input  logic                      dmDataValid,
  input  logic [maiPkg::DATA_W-1:0] dmDataWr,
  input  logic [maiPkg::MASK_W-1:0] dmMaskWr,
  input  logic                      dmEoD,
  output logic                      dmDataReady,
  // Header FIFO push side
  output logic                      hdrPush,
  output maiPkg::wrHeaderT          hdrItem,
  input  logic                      hdrFull,
  // Beat FIFO push side
  output logic                      beatPush,
  output maiPkg::wrBeatT            beatItem,
  input  logic                      beatFull
);
  import maiPkg::*;

  typedef enum logic {
    ARB_IDLE,
    ARB_DATA
  } arbStateT;

  arbStateT state;
  arbStateT stateNext;
  logic     grantDm;
  logic     pickDm;
  logic     anyValid;
  logic     inIdle;
  logic     inData;
  logic     eodAccept;
  wrHeaderT ifHdr;
  wrHeaderT dmHdr;
  wrBeatT   ifBeat;
  wrBeatT   dmBeat;

  assign inIdle = (state == ARB_IDLE);
  assign inData = (state == ARB_DATA);

  assign ifHdr = '{addr: ifAddrWr, tag: ifTagWr, id: ifIdWr, len: ifLenWr, qos: ifQoSWr};
  assign dmHdr = '{addr: dmAddrWr, tag: dmTagWr, id: dmIdWr, len: dmLenWr, qos: dmQoSWr};
  assign ifBeat = '{data: ifDataWr, mask: ifMaskWr};
  assign dmBeat = '{data: dmDataWr, mask: dmMaskWr};

  // QoS decision
  assign anyValid = ifValidWr | dmValidWr;
  assign pickDm   = dmValidWr & ~(ifValidWr & (ifQoSWr > dmQoSWr));

  // Header acceptance, same cycle as the request
  assign ifReadyWr = inIdle & ifValidWr & ~pickDm & ~hdrFull;
  assign dmReadyWr = inIdle & pickDm & ~hdrFull;
  assign hdrPush   = inIdle & anyValid & ~hdrFull;
  assign hdrItem   = pickDm ? dmHdr : ifHdr;

  // Beats only from the granted master
  assign ifDataReady = inData & ~grantDm & ~beatFull;
  assign dmDataReady = inData & grantDm & ~beatFull;
  assign beatPush    = (ifDataReady & ifDataValid) | (dmDataReady & dmDataValid);
  assign beatItem    = grantDm ? dmBeat : ifBeat;
  assign eodAccept   = beatPush & (grantDm ? dmEoD : ifEoD);

  always_comb begin
    stateNext = state;
    case (state)
      ARB_IDLE: begin
        if (hdrPush) begin
          stateNext = ARB_DATA;
        end
      end
      ARB_DATA: begin
        if (eodAccept) begin
          stateNext = ARB_IDLE;
        end
      end
      default: stateNext = ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      state   <= ARB_IDLE;
      grantDm <= 1'b0;
    end else begin
      state <= stateNext;
      if (hdrPush) begin
        grantDm <= pickDm;
      end
    end
  end

endmodule

// File: logic/burstFifo.sv
`timescale 1ns/1ps
// Single-clock FIFO for any payload type
// Push while full and pop while empty are dropped
// popItem shows the head only while empty is low
module burstFifo #(
  parameter type itemT = logic [7:0],
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic resetn,
  input  logic push,
  input  itemT pushItem,
  output logic full,
  input  logic pop,
  output itemT popItem,
  output logic empty
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  itemT             mem [DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             doPush;
  logic             doPop;

  assign full    = (count == CNT_W'(DEPTH));
  assign empty   = (count == '0);
  assign doPush  = push & ~full;
  assign doPop   = pop & ~empty;
  assign popItem = mem[rdPtr];

  always_ff @(posedge clk or negedge resetn) begin
    if (!resetn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        // Wrap explicitly so DEPTH need not be a power of two
        wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushItem;
    end
  end

endmodule

// File: logic/maiPkg.sv
// Field widths and payload layouts for the write path
// Header packs as addr, tag, id, len, qos from MSB down (45 bits)
// Length code n means 2**n beats, up to MAX_BEATS
package maiPkg;

  localparam int ADDR_W = 32;
  localparam int TAG_W  = 4;
  localparam int ID_W   = 3;
  localparam int LEN_W  = 2;
  localparam int QOS_W  = 4;
  localparam int DATA_W = 32;
  localparam int MASK_W = 4;

  // Longest burst and the counter width that can hold it
  localparam int MAX_BEATS  = 8;
  localparam int BEAT_CNT_W = $clog2(MAX_BEATS) + 1;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [TAG_W-1:0]  tag;
    logic [ID_W-1:0]   id;
    logic [LEN_W-1:0]  len;
    logic [QOS_W-1:0]  qos;
  } wrHeaderT;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [MASK_W-1:0] mask;
  } wrBeatT;

  // 0 -> 1, 1 -> 2, 2 -> 4, 3 -> 8
  function automatic logic [BEAT_CNT_W-1:0] lenToBeats(input logic [LEN_W-1:0] len);
    logic [BEAT_CNT_W-1:0] beats;
    case (len)
      2'd0: beats = BEAT_CNT_W'(1);
      2'd1: beats = BEAT_CNT_W'(2);
      2'd2: beats = BEAT_CNT_W'(4);
      default: beats = BEAT_CNT_W'(8);
    endcase
    return beats;
  endfunction

endpackage
